// File: rh_pkg.sv
package rh_pkg;

   typedef logic [23:0] pixel_t;
   typedef logic [10:0] hcount_t;
   typedef logic [9:0]  vcount_t;
   typedef logic [3:0]  note_code_t;

   localparam int NUM_NOTES = 16;
   localparam int NUM_ROWS  = 7;
   localparam int NUM_STAFF = 8;

   // note and line colours
   localparam pixel_t COLOR_WHITE   = 24'hFF_FF_FF;
   localparam pixel_t COLOR_SHARP   = 24'h55_55_FF;
   localparam pixel_t COLOR_HIGH_C  = 24'h00_DD_00;
   localparam pixel_t COLOR_CORRECT = 24'hFF_FF_00;
   localparam pixel_t COLOR_WRONG   = 24'hFF_45_00;
   localparam pixel_t COLOR_STAFF   = 24'hAA_AA_AA;
   localparam pixel_t COLOR_OFF     = 24'h00_00_00;

   localparam note_code_t CODE_REST = 4'd0;
   localparam note_code_t CODE_END  = 4'd15;

   // rest and end marker are never drawn
   function automatic logic is_hidden(note_code_t code);
      return (code == CODE_REST) || (code == CODE_END);
   endfunction

   // pitch row, row 0 at the top of the lane
   function automatic int decode_row(note_code_t code);
      case (code)
         4'd1, 4'd2, 4'd13: return 6;
         4'd3, 4'd4:        return 5;
         4'd5:              return 4;
         4'd6, 4'd7:        return 3;
         4'd8, 4'd9:        return 2;
         4'd10, 4'd11:      return 1;
         default:           return 0;
      endcase
   endfunction

   function automatic pixel_t decode_color(note_code_t code);
      case (code)
         CODE_REST, CODE_END:               return COLOR_OFF;
         4'd2, 4'd4, 4'd7, 4'd9, 4'd11:     return COLOR_SHARP;
         4'd13:                             return COLOR_HIGH_C;
         default:                           return COLOR_WHITE;
      endcase
   endfunction

endpackage

// File: video_timing.sv
`timescale 1ns/1ps

module video_timing
   import rh_pkg::*;
#(
   parameter int H_ACTIVE = 1024,
   parameter int H_FRONT  = 24,
   parameter int H_SYNC   = 136,
   parameter int H_BACK   = 160,
   parameter int V_ACTIVE = 768,
   parameter int V_FRONT  = 9,
   parameter int V_SYNC   = 6,
   parameter int V_BACK   = 23
) (
   input  logic    clk,
   input  logic    reset,
   output hcount_t hcount,
   output vcount_t vcount,
   output logic    hsync,
   output logic    vsync,
   output logic    blank
);

   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   logic hblank, vblank;
   logic hblank_on, hsync_on, hsync_off, hwrap;
   logic vblank_on, vsync_on, vsync_off, vwrap;
   logic next_hblank, next_vblank;

   // horizontal events, one cycle ahead of the registered outputs
   assign hblank_on = (hcount == hcount_t'(H_ACTIVE - 1));
   assign hsync_on  = (hcount == hcount_t'(H_ACTIVE + H_FRONT - 1));
   assign hsync_off = (hcount == hcount_t'(H_ACTIVE + H_FRONT + H_SYNC - 1));
   assign hwrap     = (hcount == hcount_t'(H_TOTAL - 1));

   // vertical events only at the end of a line
   assign vblank_on = hwrap && (vcount == vcount_t'(V_ACTIVE - 1));
   assign vsync_on  = hwrap && (vcount == vcount_t'(V_ACTIVE + V_FRONT - 1));
   assign vsync_off = hwrap && (vcount == vcount_t'(V_ACTIVE + V_FRONT + V_SYNC - 1));
   assign vwrap     = hwrap && (vcount == vcount_t'(V_TOTAL - 1));

   assign next_hblank = hwrap ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = vwrap ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   always_ff @(posedge clk) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= hwrap ? '0 : hcount + 1'b1;
         if (hwrap) begin
            vcount <= vwrap ? '0 : vcount + 1'b1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;
         // syncs are active low
         hsync  <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : hsync);
         vsync  <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : vsync);
         blank  <= next_vblank | (next_hblank & ~hwrap);
      end
   end

   hcount_in_range: assert property (@(posedge clk) disable iff (reset)
      hcount < H_TOTAL);

endmodule

// File: note_scheduler.sv
`timescale 1ns/1ps

module note_scheduler
   import rh_pkg::*;
#(
   parameter int H_ACTIVE = 1024,
   parameter int H_TOTAL  = 1344,
   parameter int V_TOTAL  = 806,
   parameter int ACTION_X = 72,
   parameter int LANE_TOP = 128,
   parameter int ROW_STEP = 73
) (
   input  logic        clk,
   input  logic        reset,
   input  hcount_t     hcount,
   input  vcount_t     vcount,
   input  logic [63:0] next_notes,
   input  logic [7:0]  beat_frames,
   input  logic        playing_correct,
   output hcount_t     lead_x,
   output vcount_t     row_y [NUM_NOTES],
   output pixel_t      note_color [NUM_NOTES]
);

   //////////////////////////////
   // frame update and beat count
   //////////////////////////////

   logic       frame_update;
   logic       beat_done;
   logic [7:0] frame_cnt;
   logic [7:0] beat_len;
   note_code_t code0;
   note_code_t code0_next;

   // last pixel of vertical blank, nothing visible depends on state here
   assign frame_update = (hcount == hcount_t'(H_TOTAL - 1)) &&
                         (vcount == vcount_t'(V_TOTAL - 1));
   assign beat_done    = (frame_cnt == beat_len - 8'd1);

   // code of the current note after this update
   assign code0_next   = beat_done ? next_notes[3:0] : code0;

   // y of a pitch row, hidden notes go below any line
   function automatic vcount_t row_pos(note_code_t code);
      if (is_hidden(code)) begin
         return '1;
      end
      return vcount_t'(LANE_TOP + decode_row(code) * ROW_STEP + 2);
   endfunction

   //////////////////////////////
   // note state
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         lead_x    <= hcount_t'(H_ACTIVE);
         frame_cnt <= '0;
         beat_len  <= beat_frames;
         code0     <= CODE_REST;
         for (int k = 0; k < NUM_NOTES; k++) begin
            row_y[k]      <= '1;
            note_color[k] <= COLOR_OFF;
         end
      end else if (frame_update) begin
         if (beat_done) begin
            frame_cnt <= '0;
            lead_x    <= hcount_t'(ACTION_X);
            code0     <= next_notes[3:0];
            for (int k = 0; k < NUM_NOTES; k++) begin
               row_y[k]      <= row_pos(next_notes[4*k +: 4]);
               note_color[k] <= decode_color(next_notes[4*k +: 4]);
            end
         end else begin
            frame_cnt <= frame_cnt + 8'd1;
            if (lead_x != '0) begin
               lead_x <= lead_x - 1'b1;
            end
         end

         // note 0 shows whether the player hits it, overrides the decode
         if (code0_next == CODE_REST) begin
            note_color[0] <= COLOR_OFF;
         end else if (playing_correct) begin
            note_color[0] <= COLOR_CORRECT;
         end else begin
            note_color[0] <= COLOR_WRONG;
         end
      end
   end

   // the scroll must never move inside a visible frame
   lead_x_frame_only: assert property (@(posedge clk) disable iff (reset)
      !$past(frame_update) && !$past(reset) |-> $stable(lead_x));

endmodule

// File: note_sprite.sv
`timescale 1ns/1ps

module note_sprite
   import rh_pkg::*;
#(
   parameter int NOTE_WIDTH  = 64,
   parameter int NOTE_HEIGHT = 35,
   parameter int ACTION_X    = 72
) (
   input  hcount_t    lead_x,
   input  logic [3:0] slot,
   input  vcount_t    row_y,
   input  pixel_t     color,
   input  hcount_t    hcount,
   input  vcount_t    vcount,
   output pixel_t     sprite_pixel
);

   // extra bits so the right and bottom edges cannot wrap
   logic [12:0] x_left;
   logic [12:0] x_right;
   logic [10:0] y_bottom;
   logic        in_x;
   logic        in_y;

   assign x_left   = 13'(lead_x) + 13'(int'(slot) * NOTE_WIDTH);
   assign x_right  = x_left + 13'(NOTE_WIDTH);
   assign y_bottom = 11'(row_y) + 11'(NOTE_HEIGHT);

   // clipped at the action line
   assign in_x = (hcount > hcount_t'(ACTION_X)) &&
                 (13'(hcount) >= x_left) && (13'(hcount) < x_right);
   assign in_y = (vcount >= row_y) && (11'(vcount) < y_bottom);

   assign sprite_pixel = (in_x && in_y) ? color : COLOR_OFF;

endmodule

// File: pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor
   import rh_pkg::*;
#(
   parameter int H_ACTIVE  = 1024,
   parameter int V_ACTIVE  = 768,
   parameter int ACTION_X  = 72,
   parameter int LANE_TOP  = 128,
   parameter int ROW_STEP  = 73,
   parameter int BAR_SHIFT = 6
) (
   input  logic       clk,
   input  logic       reset,
   input  hcount_t    tim_hcount,
   input  vcount_t    tim_vcount,
   input  logic       tim_hsync,
   input  logic       tim_vsync,
   input  logic       tim_blank,
   input  pixel_t     sprite_pixel [NUM_NOTES],
   input  logic [1:0] pattern,
   output hcount_t    hcount,
   output vcount_t    vcount,
   output logic       hsync,
   output logic       vsync,
   output logic       blank,
   output pixel_t     pixel
);

   localparam int LANE_BOTTOM = LANE_TOP + (NUM_STAFF - 1) * ROW_STEP;

   logic   in_lane_v;
   logic   in_lane_h;
   logic   action_line;
   logic   boundary_line;
   logic   border;
   pixel_t lane_px;
   pixel_t bar_px;
   pixel_t sel_px;

   //////////////////////////////
   // lane drawing
   //////////////////////////////

   assign in_lane_v     = (int'(tim_vcount) >= LANE_TOP) && (int'(tim_vcount) <= LANE_BOTTOM);
   assign in_lane_h     = (int'(tim_hcount) >= ACTION_X) && (int'(tim_hcount) < H_ACTIVE);
   assign action_line   = in_lane_v && (int'(tim_hcount) == ACTION_X);
   assign boundary_line = in_lane_v && (int'(tim_hcount) == H_ACTIVE - 1);

   always_comb begin
      lane_px = COLOR_OFF;
      for (int n = 0; n < NUM_NOTES; n++) begin
         lane_px |= sprite_pixel[n];
      end
      // staff lines span from the action line to the right edge
      for (int w = 0; w < NUM_STAFF; w++) begin
         if (in_lane_h && (int'(tim_vcount) == LANE_TOP + w * ROW_STEP)) begin
            lane_px |= COLOR_STAFF;
         end
      end
      if (action_line || boundary_line) begin
         lane_px |= COLOR_WHITE;
      end
   end

   //////////////////////////////
   // test patterns
   //////////////////////////////

   // outline of the active area
   assign border = (tim_hcount == '0) || (int'(tim_hcount) == H_ACTIVE - 1) ||
                   (tim_vcount == '0) || (int'(tim_vcount) == V_ACTIVE - 1);

   assign bar_px = {{8{tim_hcount[BAR_SHIFT + 2]}},
                    {8{tim_hcount[BAR_SHIFT + 1]}},
                    {8{tim_hcount[BAR_SHIFT]}}};

   always_comb begin
      case (pattern)
         2'd1:    sel_px = border ? COLOR_WHITE : COLOR_OFF;
         2'd2:    sel_px = bar_px;
         default: sel_px = lane_px;
      endcase
   end

   // output stage, counts and syncs stay aligned with the pixel
   always_ff @(posedge clk) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
         pixel  <= COLOR_OFF;
      end else begin
         hcount <= tim_hcount;
         vcount <= tim_vcount;
         hsync  <= tim_hsync;
         vsync  <= tim_vsync;
         blank  <= tim_blank;
         pixel  <= tim_blank ? COLOR_OFF : sel_px;
      end
   end

endmodule

// File: note_display_top.sv
`timescale 1ns/1ps

module note_display_top
   import rh_pkg::*;
#(
   parameter int H_ACTIVE    = 1024,
   parameter int H_FRONT     = 24,
   parameter int H_SYNC      = 136,
   parameter int H_BACK      = 160,
   parameter int V_ACTIVE    = 768,
   parameter int V_FRONT     = 9,
   parameter int V_SYNC      = 6,
   parameter int V_BACK      = 23,
   parameter int NOTE_WIDTH  = 64,
   parameter int NOTE_HEIGHT = 35,
   parameter int ACTION_X    = 72,
   parameter int LANE_TOP    = 128,
   parameter int ROW_STEP    = 73,
   parameter int BAR_SHIFT   = 6
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [63:0] next_notes,
   input  logic [7:0]  beat_frames,
   input  logic        playing_correct,
   input  logic [1:0]  pattern,
   output hcount_t     hcount,
   output vcount_t     vcount,
   output logic        hsync,
   output logic        vsync,
   output logic        blank,
   output pixel_t      pixel
);

   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   hcount_t tim_hcount;
   vcount_t tim_vcount;
   logic    tim_hsync;
   logic    tim_vsync;
   logic    tim_blank;
   hcount_t lead_x;
   vcount_t row_y [NUM_NOTES];
   pixel_t  note_color [NUM_NOTES];
   pixel_t  sprite_pixel [NUM_NOTES];

   video_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) u_timing (
      .clk(clk), .reset(reset),
      .hcount(tim_hcount), .vcount(tim_vcount),
      .hsync(tim_hsync), .vsync(tim_vsync), .blank(tim_blank)
   );

   note_scheduler #(
      .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
      .ACTION_X(ACTION_X), .LANE_TOP(LANE_TOP), .ROW_STEP(ROW_STEP)
   ) u_scheduler (
      .clk(clk), .reset(reset),
      .hcount(tim_hcount), .vcount(tim_vcount),
      .next_notes(next_notes), .beat_frames(beat_frames),
      .playing_correct(playing_correct),
      .lead_x(lead_x), .row_y(row_y), .note_color(note_color)
   );

   // one sprite per slot, each offset by its slot width
   for (genvar k = 0; k < NUM_NOTES; k++) begin : g_sprite
      note_sprite #(
         .NOTE_WIDTH(NOTE_WIDTH), .NOTE_HEIGHT(NOTE_HEIGHT), .ACTION_X(ACTION_X)
      ) u_sprite (
         .lead_x(lead_x), .slot(4'(k)),
         .row_y(row_y[k]), .color(note_color[k]),
         .hcount(tim_hcount), .vcount(tim_vcount),
         .sprite_pixel(sprite_pixel[k])
      );
   end

   pixel_compositor #(
      .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .ACTION_X(ACTION_X),
      .LANE_TOP(LANE_TOP), .ROW_STEP(ROW_STEP), .BAR_SHIFT(BAR_SHIFT)
   ) u_compositor (
      .clk(clk), .reset(reset),
      .tim_hcount(tim_hcount), .tim_vcount(tim_vcount),
      .tim_hsync(tim_hsync), .tim_vsync(tim_vsync), .tim_blank(tim_blank),
      .sprite_pixel(sprite_pixel), .pattern(pattern),
      .hcount(hcount), .vcount(vcount),
      .hsync(hsync), .vsync(vsync), .blank(blank), .pixel(pixel)
   );

endmodule

// File: tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic stop_run(string reason);
   $display("%s", reason);
   $display("TEST FAIL");
   $fatal(1, "simulation stopped");
endtask

task automatic check_pixel(string test, int h, int v, pixel_t expected, pixel_t actual);
   if (actual !== expected) begin
      stop_run($sformatf("ERROR %s pixel at (%0d,%0d): expected %06h, actual %06h",
                         test, h, v, expected, actual));
   end
endtask

task automatic check_count(string test, string what, int expected, int actual);
   if (actual != expected) begin
      stop_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
                         test, what, expected, actual));
   end
endtask

task automatic check_flag(string test, string what, logic expected, logic actual);
   if (actual !== expected) begin
      stop_run($sformatf("ERROR %s %s: expected %b, actual %b",
                         test, what, expected, actual));
   end
endtask

`endif

// File: tb_note_display.sv
`timescale 1ns/1ps

module tb_note_display
   import rh_pkg::*;
();

   localparam int H_ACTIVE     = 160;
   localparam int H_FRONT      = 8;
   localparam int H_SYNC       = 16;
   localparam int H_BACK       = 16;
   localparam int V_ACTIVE     = 120;
   localparam int V_FRONT      = 2;
   localparam int V_SYNC       = 3;
   localparam int V_BACK       = 5;
   localparam int NOTE_WIDTH   = 8;
   localparam int NOTE_HEIGHT  = 10;
   localparam int ACTION_X     = 12;
   localparam int LANE_TOP     = 16;
   localparam int ROW_STEP     = 12;
   localparam int BAR_SHIFT    = 5;
   localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

   // pitch row per code, -1 for rest and end
   localparam int ROW_OF [16] = '{-1, 6, 6, 5, 5, 4, 3, 3, 2, 2, 1, 1, 0, 6, 0, -1};

   logic        clk;
   logic        reset;
   logic [63:0] next_notes;
   logic [7:0]  beat_frames;
   logic        playing_correct;
   logic [1:0]  pattern;
   hcount_t     hcount;
   vcount_t     vcount;
   logic        hsync;
   logic        vsync;
   logic        blank;
   pixel_t      pixel;

   string       ph_name [$];
   int          ph_pattern [$];
   int          ph_correct [$];
   logic [63:0] ph_notes [$];
   int          ph_frames [$];
   int          ph_syncs [$];
   longint      limit_ns;

   note_code_t  m_code [NUM_NOTES];
   pixel_t      m_color0;
   int          m_lead;
   logic [7:0]  m_count;
   logic [7:0]  beat_len;
   string       cur_test;
   int          hsync_pulses;
   int          hsync_len;
   int          vsync_low;
   logic        hsync_prev;

   note_display_top #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
      .NOTE_WIDTH(NOTE_WIDTH), .NOTE_HEIGHT(NOTE_HEIGHT), .ACTION_X(ACTION_X),
      .LANE_TOP(LANE_TOP), .ROW_STEP(ROW_STEP), .BAR_SHIFT(BAR_SHIFT)
   ) DUT (
      .clk(clk), .reset(reset), .next_notes(next_notes), .beat_frames(beat_frames),
      .playing_correct(playing_correct), .pattern(pattern),
      .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync),
      .blank(blank), .pixel(pixel)
   );

   `include "tb_checks.svh"

   initial clk = 1'b0;
   always #5 clk = ~clk;

   //////////////////////////////
   // reference model
   //////////////////////////////

   function automatic pixel_t code_color(note_code_t code);
      if (code == 4'd13) begin
         return COLOR_HIGH_C;
      end
      if (code inside {4'd2, 4'd4, 4'd7, 4'd9, 4'd11}) begin
         return COLOR_SHARP;
      end
      return COLOR_WHITE;
   endfunction

   // runs where the output returns to the origin
   task automatic advance_model();
      if (m_count == beat_len - 8'd1) begin
         m_count = '0;
         m_lead  = ACTION_X;
         for (int k = 0; k < NUM_NOTES; k++) begin
            m_code[k] = next_notes[4*k +: 4];
         end
      end else begin
         m_count = m_count + 8'd1;
         if (m_lead > 0) begin
            m_lead = m_lead - 1;
         end
      end
      if (m_code[0] == CODE_REST) begin
         m_color0 = COLOR_OFF;
      end else begin
         m_color0 = playing_correct ? COLOR_CORRECT : COLOR_WRONG;
      end
   endtask

   function automatic pixel_t expected_pixel(int h, int v);
      pixel_t px;
      int     row;
      int     x0;
      int     y0;
      px = COLOR_OFF;
      if (h >= H_ACTIVE || v >= V_ACTIVE) begin
         return COLOR_OFF;
      end
      if (pattern == 2'd1) begin
         if (h == 0 || h == H_ACTIVE - 1 || v == 0 || v == V_ACTIVE - 1) begin
            px = COLOR_WHITE;
         end
         return px;
      end
      if (pattern == 2'd2) begin
         return {{8{h[BAR_SHIFT + 2]}}, {8{h[BAR_SHIFT + 1]}}, {8{h[BAR_SHIFT]}}};
      end
      for (int k = 0; k < NUM_NOTES; k++) begin
         row = ROW_OF[m_code[k]];
         x0  = m_lead + k * NOTE_WIDTH;
         y0  = LANE_TOP + row * ROW_STEP + 2;
         if (row >= 0 && h > ACTION_X && h >= x0 && h < x0 + NOTE_WIDTH &&
             v >= y0 && v < y0 + NOTE_HEIGHT) begin
            px |= (k == 0) ? m_color0 : code_color(m_code[k]);
         end
      end
      for (int w = 0; w < NUM_STAFF; w++) begin
         if (v == LANE_TOP + w * ROW_STEP && h >= ACTION_X) begin
            px |= COLOR_STAFF;
         end
      end
      if (v >= LANE_TOP && v <= LANE_TOP + (NUM_STAFF - 1) * ROW_STEP &&
          (h == ACTION_X || h == H_ACTIVE - 1)) begin
         px |= COLOR_WHITE;
      end
      return px;
   endfunction

   //////////////////////////////
   // stimulus and per-cycle checks
   //////////////////////////////

   task automatic load_stimulus();
      int          fd;
      int          beat;
      int          got_beat;
      string       line;
      string       name;
      int          pat;
      int          pc;
      logic [63:0] notes;
      int          frames;
      int          syncs;
      got_beat = 0;
      fd = $fopen("note_stimulus.txt", "r");
      if (fd == 0) begin
         stop_run("could not open note_stimulus.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") begin
            continue;
         end
         if (got_beat == 0) begin
            void'($sscanf(line, "%d", beat));
            beat_frames = 8'(beat);
            got_beat = 1;
         end else if ($sscanf(line, "%s %d %d %h %d %d",
                              name, pat, pc, notes, frames, syncs) == 6) begin
            ph_name.push_back(name);
            ph_pattern.push_back(pat);
            ph_correct.push_back(pc);
            ph_notes.push_back(notes);
            ph_frames.push_back(frames);
            ph_syncs.push_back(syncs);
         end
      end
      $fclose(fd);
      if (ph_name.size() == 0) begin
         stop_run("the stimulus file holds no test phases");
      end
   endtask

   task automatic apply_phase(int p);
      pattern         = 2'(ph_pattern[p]);
      playing_correct = (ph_correct[p] != 0);
      next_notes      = ph_notes[p];
   endtask

   task automatic check_cycle(int exp_h, int exp_v, logic first);
      @(posedge clk);
      #1;
      check_count(cur_test, "hcount", exp_h, int'(hcount));
      check_count(cur_test, "vcount", exp_v, int'(vcount));
      if (exp_h == 0 && exp_v == 0 && !first) begin
         advance_model();
      end
      check_flag(cur_test, "blank", exp_h >= H_ACTIVE || exp_v >= V_ACTIVE, blank);
      check_pixel(cur_test, exp_h, exp_v, expected_pixel(exp_h, exp_v), pixel);
      if (!hsync) begin
         if (hsync_prev) begin
            hsync_pulses++;
         end
         hsync_len++;
      end else if (!hsync_prev) begin
         check_count(cur_test, "hsync pulse length", H_SYNC, hsync_len);
         hsync_len = 0;
      end
      hsync_prev = hsync;
      if (!vsync) begin
         vsync_low++;
      end
   endtask

   task automatic run_phase(int p);
      cur_test     = ph_name[p];
      hsync_pulses = 0;
      for (int f = 0; f < ph_frames[p]; f++) begin
         vsync_low = 0;
         for (int c = 0; c < FRAME_CYCLES; c++) begin
            check_cycle(c % H_TOTAL, c / H_TOTAL, p == 0 && f == 0 && c == 0);
            // next phase inputs go in at the start of vertical blank
            if (f == ph_frames[p] - 1 && c == V_ACTIVE * H_TOTAL &&
                p + 1 < ph_name.size()) begin
               apply_phase(p + 1);
            end
         end
         check_count(cur_test, "vsync low cycles", V_SYNC * H_TOTAL, vsync_low);
      end
      check_count(cur_test, "hsync pulses", ph_syncs[p], hsync_pulses);
   endtask

   initial begin : main
      int total_frames;
      reset           = 1'b1;
      next_notes      = '0;
      beat_frames     = '0;
      playing_correct = 1'b0;
      pattern         = 2'd0;
      limit_ns        = 0;
      total_frames    = 0;
      load_stimulus();
      apply_phase(0);
      foreach (ph_frames[i]) begin
         total_frames += ph_frames[i];
      end
      limit_ns = longint'(total_frames + 2) * FRAME_CYCLES * 10;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      m_lead     = H_ACTIVE;
      m_count    = '0;
      beat_len   = beat_frames;
      m_color0   = COLOR_OFF;
      hsync_prev = 1'b1;
      hsync_len  = 0;
      for (int k = 0; k < NUM_NOTES; k++) begin
         m_code[k] = CODE_REST;
      end
      for (int p = 0; p < ph_name.size(); p++) begin
         run_phase(p);
      end
      $display("TEST PASS");
      $finish;
   end

   initial begin : watchdog
      wait (limit_ns != 0);
      #(limit_ns);
      stop_run($sformatf("timeout: the test phases did not finish within %0d ns", limit_ns));
   end

endmodule

// File: note_stimulus.txt
# first data line: beat_frames, the number of frames per beat
# then one phase per line: name pattern playing_correct next_notes(hex) frames hsync_pulses
4
reset_frame  0 0 F0EDCBA987654321 1 130
pre_beat     0 1 F0EDCBA987654321 3 390
beat_load    0 1 F0EDCBA987654321 4 520
wrong_note   0 0 3C5A7E9B1D2F4608 4 520
rest_first   0 1 E1D2C3B4A5968770 2 260
border       1 1 E1D2C3B4A5968770 2 260
color_bars   2 0 0123456789ABCDEF 2 260
lanes_back   3 0 0123456789ABCDEF 2 260
long_scroll  0 1 F0EDCBA987654321 4 520

// File: build.f
+incdir+.
rh_pkg.sv
video_timing.sv
note_scheduler.sv
note_sprite.sv
pixel_compositor.sv
note_display_top.sv
tb_note_display.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the note display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f build.f \
   --top-module tb_note_display -o tb_note_display

./obj_dir/tb_note_display > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1
